// ==== verilog/mips_fetch_pkg.sv ====
`default_nettype none

package mips_fetch_pkg;

  // A byte address or PC value.
  typedef logic [31:0] size_t;
  // One 32-bit MIPS instruction word.
  typedef logic [31:0] instr_t;
  // The major opcode field in bits 31 to 26 of a word.
  typedef logic [5:0] opcode_t;

  // Execution starts here once reset is released.
  localparam size_t RESET_VECTOR = 32'hBFC00000;
  // Major opcode of the unconditional jump J.
  localparam opcode_t OPCODE_J = 6'b000010;

  // Number of address and word pairs the instruction queue can hold.
  localparam int QUEUE_DEPTH = 4;
  // Pointer and occupancy widths that follow from the queue depth.
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  // Fetch unit FSM. The _DROP states wait for the ack to fall after req is lowered.
  typedef enum logic [2:0] {START, REQ, WAIT_DROP, PUSH, PUSH_DROP, STEP} fetch_state_t;

  // Jump resolver FSM.
  typedef enum logic [2:0] {TAKE, RETIRE, RETIRE_DROP, REDIRECT, RELEASE} resolve_state_t;

endpackage

`default_nettype wire

// ==== verilog/pc.sv ====
`timescale 1ns/1ns
`default_nettype none

module pc (
  input  logic                 clk,
  // Level-sensitive synchronous reset. The PC reads 0 from the first edge that sees it high.
  input  logic                 reset,
  // One iteration of the PC happens on every rising edge with wen high.
  input  logic                 wen,
  // Flags a branch. The target on pc_i is taken one iteration after this one.
  input  logic                 b_cond_met,
  // Branch target, sampled only when b_cond_met is high.
  input  mips_fetch_pkg::size_t pc_i,
  output mips_fetch_pkg::size_t pc_o
);

  import mips_fetch_pkg::*;

  size_t pc_q;
  // Target captured on a flagged iteration, waiting for the next one.
  size_t branch_q;
  // Set when the previous iteration flagged a branch.
  logic  sel_branch_q;
  // Previous value of reset, used to spot its release.
  logic  reset_q;

  assign pc_o = pc_q;

  always_ff @(posedge clk) begin
    reset_q <= reset;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      // Everything is cleared while reset is held.
      pc_q         <= '0;
      branch_q     <= '0;
      sel_branch_q <= 1'b0;
    end else if (reset_q) begin
      // First edge after release.
      // The PC jumps straight to the reset vector so the first fetch goes there.
      pc_q         <= RESET_VECTOR;
      branch_q     <= '0;
      sel_branch_q <= 1'b0;
    end else if (wen) begin
      // A branch flagged last time wins over the sequential step.
      // This is what gives the one-word delay before the target shows up.
      if (sel_branch_q) begin
        pc_q <= branch_q;
      end else begin
        pc_q <= pc_q + size_t'(4);
      end
      // The target is only captured when a branch is flagged.
      // Otherwise the old one is kept, though it will not be selected.
      if (b_cond_met) begin
        branch_q <= pc_i;
      end
      sel_branch_q <= b_cond_met;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
  input  logic                   clk,
  input  logic                   reset,
  // Instruction memory port. This side is the requester.
  output logic                   imem_req,
  output mips_fetch_pkg::size_t  imem_addr,
  input  logic                   imem_ack,
  input  mips_fetch_pkg::instr_t imem_data,
  // Push side towards the instruction queue.
  output logic                   push_req,
  output mips_fetch_pkg::size_t  push_pc,
  output mips_fetch_pkg::instr_t push_instr,
  input  logic                   push_ack,
  // Redirect requests from the jump resolver.
  input  logic                   jump_req,
  input  mips_fetch_pkg::size_t  jump_target,
  output logic                   jump_ack
);

  import mips_fetch_pkg::*;

  fetch_state_t state;
  // Word returned by the memory, held until the queue has taken it.
  instr_t       instr_q;
  size_t        pc_o;
  logic         wen;
  logic         b_cond_met;

  // The PC only moves in STEP, so it stays stable through both handshakes.
  // It therefore serves as the memory address and as the pushed address.
  assign imem_addr  = pc_o;
  assign push_pc    = pc_o;
  assign push_instr = instr_q;

  // STEP is a single cycle and always iterates the PC.
  assign wen = (state == STEP);
  // A pending redirect is folded into that iteration as a branch.
  assign b_cond_met = (state == STEP) && jump_req && !jump_ack;

  pc pc_inst (
    .clk        (clk),
    .reset      (reset),
    .wen        (wen),
    .b_cond_met (b_cond_met),
    .pc_i       (jump_target),
    .pc_o       (pc_o)
  );

  // Latch the fetched word when the memory acknowledges.
  always_ff @(posedge clk) begin
    if (state == REQ && imem_ack) begin
      instr_q <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= START;
      imem_req <= 1'b0;
      push_req <= 1'b0;
      jump_ack <= 1'b0;
    end else begin
      // The redirect ack is released once the resolver lowers its request.
      if (jump_ack && !jump_req) begin
        jump_ack <= 1'b0;
      end
      case (state)
        START: begin
          // The PC loads the reset vector on this same edge.
          imem_req <= 1'b1;
          state    <= REQ;
        end
        REQ: begin
          if (imem_ack) begin
            imem_req <= 1'b0;
            state    <= WAIT_DROP;
          end
        end
        WAIT_DROP: begin
          // No push is offered until the memory has closed its side.
          if (!imem_ack) begin
            push_req <= 1'b1;
            state    <= PUSH;
          end
        end
        PUSH: begin
          // A full queue keeps push_ack low and holds us here.
          if (push_ack) begin
            push_req <= 1'b0;
            state    <= PUSH_DROP;
          end
        end
        PUSH_DROP: begin
          if (!push_ack) begin
            state <= STEP;
          end
        end
        STEP: begin
          if (b_cond_met) begin
            jump_ack <= 1'b1;
          end
          // The new PC value appears together with the next request.
          imem_req <= 1'b1;
          state    <= REQ;
        end
        default: begin
          state <= START;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/instr_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_queue (
  input  logic                   clk,
  input  logic                   reset,
  // Push side. The fetch unit requests and this queue answers.
  input  logic                   push_req,
  input  mips_fetch_pkg::size_t  push_pc,
  input  mips_fetch_pkg::instr_t push_instr,
  output logic                   push_ack,
  // Pop side. This queue requests and the jump resolver answers.
  output logic                   pop_req,
  output mips_fetch_pkg::size_t  pop_pc,
  output mips_fetch_pkg::instr_t pop_instr,
  input  logic                   pop_ack
);

  import mips_fetch_pkg::*;

  size_t                  mem_pc    [QUEUE_DEPTH];
  instr_t                 mem_instr [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_CNT_W-1:0] count;
  logic                   do_push;
  logic                   do_pop;

  // An entry is stored only if there is room. Otherwise push_ack stays low.
  assign do_push = push_req && !push_ack && (count < QUEUE_CNT_W'(QUEUE_DEPTH));
  // The head leaves when the resolver acknowledges it.
  assign do_pop  = pop_req && pop_ack;

  // The head is shown directly and only changes when it is removed.
  assign pop_pc    = mem_pc[rd_ptr];
  assign pop_instr = mem_instr[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_pc[wr_ptr]    <= push_pc;
      mem_instr[wr_ptr] <= push_instr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      push_ack <= 1'b0;
      pop_req  <= 1'b0;
    end else begin
      if (do_push) begin
        push_ack <= 1'b1;
        if (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end else if (push_ack && !push_req) begin
        push_ack <= 1'b0;
      end

      // A new offer waits until the previous pop_ack has fallen.
      if (do_pop) begin
        pop_req <= 1'b0;
        if (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end else if (!pop_req && !pop_ack && count != '0) begin
        pop_req <= 1'b1;
      end

      // Push and pop can land on the same edge and cancel out.
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/jump_resolver.sv ====
`timescale 1ns/1ns
`default_nettype none

module jump_resolver (
  input  logic                   clk,
  input  logic                   reset,
  // Entries offered by the instruction queue.
  input  logic                   pop_req,
  input  mips_fetch_pkg::size_t  pop_pc,
  input  mips_fetch_pkg::instr_t pop_instr,
  output logic                   pop_ack,
  // Redirect towards the fetch unit.
  output logic                   jump_req,
  output mips_fetch_pkg::size_t  jump_target,
  input  logic                   jump_ack,
  // Retired instructions in program order.
  output logic                   retire_req,
  output mips_fetch_pkg::size_t  retire_pc,
  output mips_fetch_pkg::instr_t retire_instr,
  input  logic                   retire_ack
);

  import mips_fetch_pkg::*;

  resolve_state_t state;
  size_t          cur_pc;
  instr_t         cur_instr;
  opcode_t        cur_op;
  size_t          cur_pc_plus4;
  size_t          target_calc;
  // The entry being retired is the delay slot of a jump.
  logic           in_slot;
  // Entries are discarded until the one at jump_target shows up.
  logic           dropping;
  logic           take;
  logic           load_target;

  assign retire_pc    = cur_pc;
  assign retire_instr = cur_instr;

  assign cur_op       = cur_instr[31:26];
  assign cur_pc_plus4 = cur_pc + size_t'(4);
  // J keeps the region bits of the delay slot address and replaces the rest.
  assign target_calc  = {cur_pc_plus4[31:28], cur_instr[25:0], 2'b00};

  assign take = (state == TAKE) && pop_req && !pop_ack;
  // A J found in a delay slot is not acted on.
  assign load_target = (state == RETIRE_DROP) && !retire_ack && !in_slot &&
                       (cur_op == OPCODE_J);

  always_ff @(posedge clk) begin
    if (take) begin
      cur_pc    <= pop_pc;
      cur_instr <= pop_instr;
    end
    if (load_target) begin
      jump_target <= target_calc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= TAKE;
      pop_ack    <= 1'b0;
      jump_req   <= 1'b0;
      retire_req <= 1'b0;
      in_slot    <= 1'b0;
      dropping   <= 1'b0;
    end else begin
      // The queue lowers pop_req after the removal, then pop_ack follows.
      if (pop_ack && !pop_req) begin
        pop_ack <= 1'b0;
      end
      case (state)
        TAKE: begin
          if (take) begin
            pop_ack <= 1'b1;
            // A wrong-path entry is acknowledged and thrown away here.
            if (!dropping || pop_pc == jump_target) begin
              dropping   <= 1'b0;
              retire_req <= 1'b1;
              state      <= RETIRE;
            end
          end
        end
        RETIRE: begin
          if (retire_ack) begin
            retire_req <= 1'b0;
            state      <= RETIRE_DROP;
          end
        end
        RETIRE_DROP: begin
          if (!retire_ack) begin
            if (in_slot) begin
              // The delay slot is done. Anything up to the target is stale.
              in_slot  <= 1'b0;
              dropping <= 1'b1;
              state    <= TAKE;
            end else if (load_target) begin
              jump_req <= 1'b1;
              state    <= REDIRECT;
            end else begin
              state <= TAKE;
            end
          end
        end
        REDIRECT: begin
          if (jump_ack) begin
            jump_req <= 1'b0;
            state    <= RELEASE;
          end
        end
        RELEASE: begin
          // The next entry taken is the delay slot.
          if (!jump_ack) begin
            in_slot <= 1'b1;
            state   <= TAKE;
          end
        end
        default: begin
          state <= TAKE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
  input  logic                   clk,
  input  logic                   reset,
  // External instruction memory.
  output logic                   imem_req,
  output mips_fetch_pkg::size_t  imem_addr,
  input  logic                   imem_ack,
  input  mips_fetch_pkg::instr_t imem_data,
  // Retired instructions in program order.
  output logic                   retire_req,
  output mips_fetch_pkg::size_t  retire_pc,
  output mips_fetch_pkg::instr_t retire_instr,
  input  logic                   retire_ack
);

  import mips_fetch_pkg::*;

  // Fetch unit to queue.
  logic   push_req;
  size_t  push_pc;
  instr_t push_instr;
  logic   push_ack;
  // Queue to jump resolver.
  logic   pop_req;
  size_t  pop_pc;
  instr_t pop_instr;
  logic   pop_ack;
  // Jump resolver back to the fetch unit.
  logic   jump_req;
  size_t  jump_target;
  logic   jump_ack;

  fetch_unit fetch_unit_inst (
    .clk         (clk),
    .reset       (reset),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .imem_ack    (imem_ack),
    .imem_data   (imem_data),
    .push_req    (push_req),
    .push_pc     (push_pc),
    .push_instr  (push_instr),
    .push_ack    (push_ack),
    .jump_req    (jump_req),
    .jump_target (jump_target),
    .jump_ack    (jump_ack)
  );

  // Decouples fetching from retirement so fetching can run ahead.
  instr_queue instr_queue_inst (
    .clk        (clk),
    .reset      (reset),
    .push_req   (push_req),
    .push_pc    (push_pc),
    .push_instr (push_instr),
    .push_ack   (push_ack),
    .pop_req    (pop_req),
    .pop_pc     (pop_pc),
    .pop_instr  (pop_instr),
    .pop_ack    (pop_ack)
  );

  jump_resolver jump_resolver_inst (
    .clk          (clk),
    .reset        (reset),
    .pop_req      (pop_req),
    .pop_pc       (pop_pc),
    .pop_instr    (pop_instr),
    .pop_ack      (pop_ack),
    .jump_req     (jump_req),
    .jump_target  (jump_target),
    .jump_ack     (jump_ack),
    .retire_req   (retire_req),
    .retire_pc    (retire_pc),
    .retire_instr (retire_instr),
    .retire_ack   (retire_ack)
  );

endmodule

`default_nettype wire

// ==== test/fetch_top_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_top_asserts (
  input logic                  clk,
  input logic                  reset,
  input logic                  imem_req,
  input mips_fetch_pkg::size_t imem_addr,
  input logic                  imem_ack,
  input logic                  push_req,
  input logic                  push_ack,
  input logic                  pop_req,
  input logic                  pop_ack,
  input logic                  jump_req,
  input logic                  jump_ack,
  input logic                  retire_req,
  input mips_fetch_pkg::size_t retire_pc,
  input logic                  retire_ack
);

  // A request stays up until its ack has been seen.
  imem_req_held: assert property (@(posedge clk) disable iff (reset)
    imem_req && !imem_ack |=> imem_req)
    else $error("imem_req fell before imem_ack");
  push_req_held: assert property (@(posedge clk) disable iff (reset)
    push_req && !push_ack |=> push_req)
    else $error("push_req fell before push_ack");
  pop_req_held: assert property (@(posedge clk) disable iff (reset)
    pop_req && !pop_ack |=> pop_req)
    else $error("pop_req fell before pop_ack");
  jump_req_held: assert property (@(posedge clk) disable iff (reset)
    jump_req && !jump_ack |=> jump_req)
    else $error("jump_req fell before jump_ack");
  retire_req_held: assert property (@(posedge clk) disable iff (reset)
    retire_req && !retire_ack |=> retire_req)
    else $error("retire_req fell before retire_ack");

  // The acks raised inside the design never come up while their request is low.
  push_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    !push_req && !push_ack |=> !push_ack)
    else $error("push_ack rose while push_req was low");
  pop_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    !pop_req && !pop_ack |=> !pop_ack)
    else $error("pop_ack rose while pop_req was low");
  jump_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    !jump_req && !jump_ack |=> !jump_ack)
    else $error("jump_ack rose while jump_req was low");

  // Address lines hold still while a request waits.
  imem_addr_stable: assert property (@(posedge clk) disable iff (reset)
    imem_req && !imem_ack |=> $stable(imem_addr))
    else $error("imem_addr changed during a request");
  retire_pc_stable: assert property (@(posedge clk) disable iff (reset)
    retire_req && !retire_ack |=> $stable(retire_pc))
    else $error("retire_pc changed during a request");

endmodule

bind fetch_top fetch_top_asserts fetch_top_asserts_inst (
  .clk        (clk),
  .reset      (reset),
  .imem_req   (imem_req),
  .imem_addr  (imem_addr),
  .imem_ack   (imem_ack),
  .push_req   (push_req),
  .push_ack   (push_ack),
  .pop_req    (pop_req),
  .pop_ack    (pop_ack),
  .jump_req   (jump_req),
  .jump_ack   (jump_ack),
  .retire_req (retire_req),
  .retire_pc  (retire_pc),
  .retire_ack (retire_ack)
);

`default_nettype wire

// ==== test/fetch_top_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_top_tb;

  import mips_fetch_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 10;
  // The program covers the first 17 words after the reset vector.
  localparam int PROG_WORDS = 17;
  // Retirements checked after each of the two resets.
  localparam int RETIRES_PER_RUN = 60;
  localparam int RUNS = 2;
  localparam int CYCLES_PER_RETIRE = 40;
  // Slack of one queue load per run covers the wrong-path words still in flight.
  localparam int CYCLE_LIMIT =
    RUNS * ((RETIRES_PER_RUN + QUEUE_DEPTH) * CYCLES_PER_RETIRE + RESET_CYCLES);

  logic   clk;
  logic   reset = 1'b1;
  logic   imem_req;
  size_t  imem_addr;
  logic   imem_ack = 1'b0;
  instr_t imem_data = '0;
  logic   retire_req;
  size_t  retire_pc;
  instr_t retire_instr;
  logic   retire_ack = 1'b0;

  instr_t program_mem [PROG_WORDS];
  integer seed = 32'h9eec;
  // Remaining wait before an ack, or -1 when no delay has been drawn yet.
  int     imem_wait;
  int     retire_wait;
  int     retire_count;
  logic   retire_req_q;
  int     cycle_count;

  fetch_top fetch_top_inst (
    .clk          (clk),
    .reset        (reset),
    .imem_req     (imem_req),
    .imem_addr    (imem_addr),
    .imem_ack     (imem_ack),
    .imem_data    (imem_data),
    .retire_req   (retire_req),
    .retire_pc    (retire_pc),
    .retire_instr (retire_instr),
    .retire_ack   (retire_ack)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Word stored at a byte address. Everything outside the program reads as a nop.
  function automatic instr_t program_word(input size_t addr);
    size_t offset;
    offset = addr - RESET_VECTOR;
    if (offset < size_t'(PROG_WORDS * 4)) begin
      return program_mem[int'(offset >> 2)];
    end else begin
      return '0;
    end
  endfunction

  // Walks the program in architectural order from the reset vector.
  // Returns the address in the upper half and the word in the lower half.
  function automatic logic [63:0] expected_retire(input int n);
    size_t  addr;
    size_t  slot_addr;
    size_t  target;
    logic   jump_pending;
    instr_t word;
    int     i;
    addr         = RESET_VECTOR;
    target       = '0;
    jump_pending = 1'b0;
    for (i = 0; i < n; i++) begin
      word = program_word(addr);
      if (jump_pending) begin
        // The delay slot has run, so control now moves to the jump target.
        jump_pending = 1'b0;
        addr         = target;
      end else begin
        slot_addr = addr + 32'd4;
        if (word[31:26] == OPCODE_J) begin
          // J keeps the top four bits of the delay slot address.
          target       = {slot_addr[31:28], word[25:0], 2'b00};
          jump_pending = 1'b1;
        end
        addr = slot_addr;
      end
    end
    return {addr, program_word(addr)};
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got %08h, expected %08h", name, actual, expected);
      $display("Test failed");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic wait_for_retires();
    while (retire_count < RETIRES_PER_RUN) begin
      @(posedge clk);
    end
  endtask

  // Memory and retire sink. Both delays are drawn here so the random sequence is fixed.
  always @(negedge clk) begin
    if (reset) begin
      imem_ack    = 1'b0;
      imem_wait   = -1;
      retire_ack  = 1'b0;
      retire_wait = -1;
    end else begin
      if (imem_ack) begin
        // The ack falls once the fetch unit has withdrawn its request.
        if (!imem_req) begin
          imem_ack = 1'b0;
        end
      end else if (imem_req) begin
        if (imem_wait < 0) begin
          imem_wait = $random(seed) & 3;
        end
        if (imem_wait == 0) begin
          imem_data = program_word(imem_addr);
          imem_ack  = 1'b1;
          imem_wait = -1;
        end else begin
          imem_wait = imem_wait - 1;
        end
      end
      if (retire_ack) begin
        if (!retire_req) begin
          retire_ack = 1'b0;
        end
      end else if (retire_req) begin
        // Long waits here let the queue fill up behind the resolver.
        if (retire_wait < 0) begin
          retire_wait = $unsigned($random(seed)) % 6;
        end
        if (retire_wait == 0) begin
          retire_ack  = 1'b1;
          retire_wait = -1;
        end else begin
          retire_wait = retire_wait - 1;
        end
      end
    end
  end

  // Each rising retire_req is one retirement, checked against the reference order.
  always @(negedge clk) begin
    logic [63:0] expected;
    if (reset) begin
      retire_count = 0;
      retire_req_q = 1'b0;
    end else begin
      if (retire_req && !retire_req_q) begin
        expected = expected_retire(retire_count);
        check_value("retire_pc", retire_pc, expected[63:32]);
        check_value("retire_instr", retire_instr, expected[31:0]);
        retire_count = retire_count + 1;
      end
      retire_req_q = retire_req;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Test failed");
      $fatal(1, "Timeout after %0d cycles before all retirements were seen", cycle_count);
    end
  end

  initial begin
    // Straight-line start, then a forward J over wrong-path words.
    program_mem[0]  = 32'h24010001;
    program_mem[1]  = 32'h24020002;
    program_mem[2]  = 32'h0BF0000A;
    program_mem[3]  = 32'h24030003;
    // Wrong path of the first J. It holds a J back to the reset vector that must be ignored.
    program_mem[4]  = 32'h24040004;
    program_mem[5]  = 32'h24050005;
    program_mem[6]  = 32'h0BF00000;
    program_mem[7]  = 32'h24070007;
    program_mem[8]  = 32'h24080008;
    program_mem[9]  = 32'h24090009;
    // Loop body at offset 0x28 closed by a backward J with its delay slot.
    program_mem[10] = 32'h240A000A;
    program_mem[11] = 32'h240B000B;
    program_mem[12] = 32'h240C000C;
    program_mem[13] = 32'h0BF0000A;
    program_mem[14] = 32'h240E000E;
    program_mem[15] = 32'h240F000F;
    program_mem[16] = 32'h24100010;
    cycle_count = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset <= 1'b0;
    wait_for_retires();
    // Reset in the middle of the loop restarts retirement from the reset vector.
    @(negedge clk);
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    reset <= 1'b0;
    wait_for_retires();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/mips_fetch_pkg.sv
verilog/pc.sv
verilog/fetch_unit.sv
verilog/instr_queue.sv
verilog/jump_resolver.sv
verilog/fetch_top.sv
test/fetch_top_asserts.sv
test/fetch_top_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the fetch testbench with Verilator and runs it.
# The script's exit status is the simulation's own.
cd "$(dirname "$0")" &&
  verilator --binary --assert --top-module fetch_top_tb -f verilog.f \
    --Mdir obj_dir -o fetch_top_sim &&
  ./obj_dir/fetch_top_sim ||
  exit 1
